// ==== hw/board_bus_consts.svh ====
// bus widths, address-space codes, main register indices, read-source codes, ip reset value
`ifndef BOARD_BUS_CONSTS_SVH
`define BOARD_BUS_CONSTS_SVH

// ------------------------------------------------------------
// widths
// ------------------------------------------------------------
`define BUS_ADDR_W     16                // register address
`define BUS_DATA_W     32                // register data
`define BW_ADDR_W      8                 // block writer address, zero-extended on bus
`define RT_ADDR_W      4                 // real-time write port address
`define SAMPLE_ADDR_W  6                 // sample buffer address
`define CHAN_W         4                 // sampling channel

// ------------------------------------------------------------
// address spaces, taken from addr[15:12]
// ------------------------------------------------------------
`define ADDR_MAIN      4'd0
`define ADDR_HUB       4'd1
`define ADDR_PROM      4'd2
`define ADDR_ETH       4'd4
`define ADDR_FW        4'd5

// main space register indices, addr[3:0]
`define REG_PROMSTAT   4'd8
`define REG_PROMRES    4'd9
`define REG_IPADDR     4'd11
`define REG_ETHRES     4'd12

// ------------------------------------------------------------
// read-source codes from decoder to router
// ------------------------------------------------------------
`define RD_SRC_W       4
`define RD_SRC_EXT      4'd0             // falls out to board registers
`define RD_SRC_HUB      4'd1
`define RD_SRC_PROM     4'd2
`define RD_SRC_ETH      4'd3             // ethernet io | mac chip
`define RD_SRC_FW       4'd4
`define RD_SRC_PROMSTAT 4'd5
`define RD_SRC_PROMRES  4'd6
`define RD_SRC_IPADDR   4'd7
`define RD_SRC_ETHRES   4'd8

`define IP_ADDR_RESET  32'hFFFF_FFFF     // unassigned ip after reset

`endif

// ==== hw/board_bus_pkg.sv ====
// register address union with main and memory-space views
`include "board_bus_consts.svh"

package board_bus_pkg;

    // main space register word
    typedef struct packed {
        logic [3:0] space;               // address space code
        logic [3:0] board;               // board field, 0 for local
        logic [3:0] chan;                // channel, 0 for board-wide regs
        logic [3:0] index;               // register index
    } reg_main_s;

    // memory spaces use a flat offset
    typedef struct packed {
        logic [3:0]                space;
        logic [`BUS_ADDR_W-5:0]    offset;   // word offset inside the space
    } reg_mem_s;

    // same 16 bits seen both ways
    typedef union packed {
        reg_main_s main_view;
        reg_mem_s  mem_view;
    } reg_addr_u;

endpackage

// ==== hw/wr_bus_if.sv ====
// internal register write bus with arbiter and sink modports
`include "board_bus_consts.svh"

interface wr_bus_if;

    logic                      reg_wen;      // single-cycle register write strobe
    logic                      blk_wen;      // block write word strobe
    logic                      blk_wstart;   // block write is starting
    board_bus_pkg::reg_addr_u  reg_waddr;    // write address
    logic [`BUS_DATA_W-1:0]    reg_wdata;    // write data

    // winning master drives the bus
    modport arb (
        output reg_wen,
        output blk_wen,
        output blk_wstart,
        output reg_waddr,
        output reg_wdata
    );

    // decoder, router and top level listen
    modport snk (
        input  reg_wen,
        input  blk_wen,
        input  blk_wstart,
        input  reg_waddr,
        input  reg_wdata
    );

endinterface

// ==== hw/host_bus_arbiter.sv ====
// master selection for write bus, read address, real-time port and sampling
`include "board_bus_consts.svh"

module host_bus_arbiter (
    // firewire master
    input  logic [`BUS_ADDR_W-1:0]     fw_reg_raddr,
    input  logic [`BUS_ADDR_W-1:0]     fw_reg_waddr,
    input  logic [`BUS_DATA_W-1:0]     fw_reg_wdata,
    input  logic                       fw_reg_wen,
    input  logic                       fw_blk_wen,
    input  logic                       fw_blk_wstart,
    input  logic                       fw_rt_wen,
    input  logic [`RT_ADDR_W-1:0]      fw_rt_waddr,
    input  logic [`BUS_DATA_W-1:0]     fw_rt_wdata,
    input  logic                       fw_sample_start,
    input  logic [`SAMPLE_ADDR_W-1:0]  fw_sample_raddr,
    // ethernet master
    input  logic                       eth_read_en,      // eth owns reg_raddr
    input  logic                       eth_write_en,     // eth owns write bus
    input  logic [`BUS_ADDR_W-1:0]     eth_reg_raddr,
    input  logic [`BUS_ADDR_W-1:0]     eth_reg_waddr,
    input  logic [`BUS_DATA_W-1:0]     eth_reg_wdata,
    input  logic                       eth_reg_wen,
    input  logic                       eth_blk_wen,
    input  logic                       eth_blk_wstart,
    input  logic                       eth_rt_wen,
    input  logic [`RT_ADDR_W-1:0]      eth_rt_waddr,
    input  logic [`BUS_DATA_W-1:0]     eth_rt_wdata,
    input  logic                       eth_sample_start,
    input  logic                       eth_sample_read,  // eth owns sample_raddr
    input  logic [`SAMPLE_ADDR_W-1:0]  eth_sample_raddr,
    // real-time block writer
    input  logic                       bw_write_en,      // highest write priority
    input  logic [`BW_ADDR_W-1:0]      bw_reg_waddr,
    input  logic [`BUS_DATA_W-1:0]     bw_reg_wdata,
    input  logic                       bw_reg_wen,
    input  logic                       bw_blk_wen,
    input  logic                       bw_blk_wstart,
    // data sampler
    input  logic                       sample_busy,      // sampler owns reg_raddr
    input  logic [`CHAN_W-1:0]         sample_chan,
    // selected outputs
    wr_bus_if.arb                      wr,
    output board_bus_pkg::reg_addr_u   reg_raddr,
    output logic                       rt_wen,
    output logic [`RT_ADDR_W-1:0]      rt_waddr,
    output logic [`BUS_DATA_W-1:0]     rt_wdata,
    output logic                       sample_start,
    output logic [`SAMPLE_ADDR_W-1:0]  sample_raddr
);

    // ------------------------------------------------------------
    // write bus: block writer > ethernet > firewire
    // ------------------------------------------------------------
    always_comb begin
        if (bw_write_en) begin
            wr.reg_wen    = bw_reg_wen;
            wr.blk_wen    = bw_blk_wen;
            wr.blk_wstart = bw_blk_wstart;
            wr.reg_waddr  = {{(`BUS_ADDR_W-`BW_ADDR_W){1'b0}}, bw_reg_waddr};  // zero-extend
            wr.reg_wdata  = bw_reg_wdata;
        end else if (eth_write_en) begin
            wr.reg_wen    = eth_reg_wen;
            wr.blk_wen    = eth_blk_wen;
            wr.blk_wstart = eth_blk_wstart;
            wr.reg_waddr  = eth_reg_waddr;
            wr.reg_wdata  = eth_reg_wdata;
        end else begin
            wr.reg_wen    = fw_reg_wen;           // firewire is the default owner
            wr.blk_wen    = fw_blk_wen;
            wr.blk_wstart = fw_blk_wstart;
            wr.reg_waddr  = fw_reg_waddr;
            wr.reg_wdata  = fw_reg_wdata;
        end
    end

    // ------------------------------------------------------------
    // read address: sampler > ethernet > firewire
    // ------------------------------------------------------------
    always_comb begin
        if (sample_busy) begin
            reg_raddr.main_view.space = `ADDR_MAIN;  // channel reg 0 of this board
            reg_raddr.main_view.board = 4'd0;
            reg_raddr.main_view.chan  = sample_chan;
            reg_raddr.main_view.index = 4'd0;
        end else if (eth_read_en) begin
            reg_raddr = eth_reg_raddr;
        end else begin
            reg_raddr = fw_reg_raddr;
        end
    end

    // real-time port, eth wins while its strobe is up
    assign rt_wen   = eth_rt_wen ? eth_rt_wen   : fw_rt_wen;
    assign rt_waddr = eth_rt_wen ? eth_rt_waddr : fw_rt_waddr;
    assign rt_wdata = eth_rt_wen ? eth_rt_wdata : fw_rt_wdata;

    // sampling shared by both hosts, start ignored while busy
    assign sample_start = (eth_sample_start | fw_sample_start) & ~sample_busy;
    assign sample_raddr = eth_sample_read ? eth_sample_raddr : fw_sample_raddr;

endmodule

// ==== hw/reg_addr_decoder.sv ====
// read address classification and ip register write detect
`include "board_bus_consts.svh"

module reg_addr_decoder (
    input  board_bus_pkg::reg_addr_u  reg_raddr,     // selected read address
    wr_bus_if.snk                     wr,            // write bus
    output logic [`RD_SRC_W-1:0]      rd_src,        // read-source code
    output logic                      ip_wr_hit      // write to ip register this cycle
);

    logic main_sel;                                  // board-wide main register

    assign main_sel = (reg_raddr.main_view.chan == 4'd0);

    // ------------------------------------------------------------
    // space first, then main index
    // ------------------------------------------------------------
    always_comb begin
        rd_src = `RD_SRC_EXT;                        // everything unclaimed
        case (reg_raddr.mem_view.space)
            `ADDR_HUB:  rd_src = `RD_SRC_HUB;
            `ADDR_PROM: rd_src = `RD_SRC_PROM;
            `ADDR_ETH:  rd_src = `RD_SRC_ETH;
            `ADDR_FW:   rd_src = `RD_SRC_FW;
            `ADDR_MAIN: begin
                if (main_sel) begin
                    case (reg_raddr.main_view.index)
                        `REG_PROMSTAT: rd_src = `RD_SRC_PROMSTAT;
                        `REG_PROMRES:  rd_src = `RD_SRC_PROMRES;
                        `REG_IPADDR:   rd_src = `RD_SRC_IPADDR;
                        `REG_ETHRES:   rd_src = `RD_SRC_ETHRES;
                        default:       rd_src = `RD_SRC_EXT;
                    endcase
                end
            end
            default:    rd_src = `RD_SRC_EXT;
        endcase
    end

    // exact match on main/board 0/chan 0/ipaddr, qualified by the strobe
    assign ip_wr_hit = wr.reg_wen
                     && (wr.reg_waddr.mem_view.space  == `ADDR_MAIN)
                     && (wr.reg_waddr.main_view.board == 4'd0)
                     && (wr.reg_waddr.main_view.chan  == 4'd0)
                     && (wr.reg_waddr.main_view.index == `REG_IPADDR);

endmodule

// ==== hw/rdata_router.sv ====
// read data mux and board ip address register
`include "board_bus_consts.svh"

module rdata_router (
    input  logic                     sysclk,
    input  logic                     arst_n,
    input  logic [`RD_SRC_W-1:0]     rd_src,          // from decoder
    input  logic                     ip_wr_hit,       // load ip register
    wr_bus_if.snk                    wr,              // supplies write data
    input  logic [`BUS_DATA_W-1:0]   reg_rdata_hub,   // hub memory
    input  logic [`BUS_DATA_W-1:0]   reg_rdata_prom,  // prom block read
    input  logic [`BUS_DATA_W-1:0]   reg_rdata_eth,   // ethernet io memory
    input  logic [`BUS_DATA_W-1:0]   reg_rdata_ksz,   // mac chip memory
    input  logic [`BUS_DATA_W-1:0]   reg_rdata_fw,    // firewire packet memory
    input  logic [`BUS_DATA_W-1:0]   prom_status,
    input  logic [`BUS_DATA_W-1:0]   prom_result,
    input  logic [`BUS_DATA_W-1:0]   eth_result,      // mac status | last read
    input  logic [`BUS_DATA_W-1:0]   reg_rdata_ext,   // board registers outside
    output logic [`BUS_DATA_W-1:0]   reg_rdata,
    output logic [`BUS_DATA_W-1:0]   ip_address
);

    // ------------------------------------------------------------
    // ip address register
    // ------------------------------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            ip_address <= `IP_ADDR_RESET;
        end else if (ip_wr_hit) begin
            ip_address <= wr.reg_wdata;               // visible next cycle
        end
    end

    // ------------------------------------------------------------
    // read data select
    // ------------------------------------------------------------
    always_comb begin
        case (rd_src)
            `RD_SRC_HUB:      reg_rdata = reg_rdata_hub;
            `RD_SRC_PROM:     reg_rdata = reg_rdata_prom;
            `RD_SRC_ETH:      reg_rdata = reg_rdata_eth | reg_rdata_ksz;  // only one drives
            `RD_SRC_FW:       reg_rdata = reg_rdata_fw;
            `RD_SRC_PROMSTAT: reg_rdata = prom_status;
            `RD_SRC_PROMRES:  reg_rdata = prom_result;
            `RD_SRC_IPADDR:   reg_rdata = ip_address;
            `RD_SRC_ETHRES:   reg_rdata = eth_result;
            default:          reg_rdata = reg_rdata_ext;
        endcase
    end

endmodule

// ==== hw/board_bus_top.sv ====
// board register bus top level with arbiter, decoder and read router
`include "board_bus_consts.svh"

module board_bus_top (
    input  logic                       sysclk,
    input  logic                       arst_n,
    // firewire master
    input  logic [`BUS_ADDR_W-1:0]     fw_reg_raddr,
    input  logic [`BUS_ADDR_W-1:0]     fw_reg_waddr,
    input  logic [`BUS_DATA_W-1:0]     fw_reg_wdata,
    input  logic                       fw_reg_wen,
    input  logic                       fw_blk_wen,
    input  logic                       fw_blk_wstart,
    input  logic                       fw_rt_wen,
    input  logic [`RT_ADDR_W-1:0]      fw_rt_waddr,
    input  logic [`BUS_DATA_W-1:0]     fw_rt_wdata,
    input  logic                       fw_sample_start,
    input  logic [`SAMPLE_ADDR_W-1:0]  fw_sample_raddr,
    // ethernet master
    input  logic                       eth_read_en,
    input  logic                       eth_write_en,
    input  logic [`BUS_ADDR_W-1:0]     eth_reg_raddr,
    input  logic [`BUS_ADDR_W-1:0]     eth_reg_waddr,
    input  logic [`BUS_DATA_W-1:0]     eth_reg_wdata,
    input  logic                       eth_reg_wen,
    input  logic                       eth_blk_wen,
    input  logic                       eth_blk_wstart,
    input  logic                       eth_rt_wen,
    input  logic [`RT_ADDR_W-1:0]      eth_rt_waddr,
    input  logic [`BUS_DATA_W-1:0]     eth_rt_wdata,
    input  logic                       eth_sample_start,
    input  logic                       eth_sample_read,
    input  logic [`SAMPLE_ADDR_W-1:0]  eth_sample_raddr,
    // block writer
    input  logic                       bw_write_en,
    input  logic [`BW_ADDR_W-1:0]      bw_reg_waddr,
    input  logic [`BUS_DATA_W-1:0]     bw_reg_wdata,
    input  logic                       bw_reg_wen,
    input  logic                       bw_blk_wen,
    input  logic                       bw_blk_wstart,
    // sampler
    input  logic                       sample_busy,
    input  logic [`CHAN_W-1:0]         sample_chan,
    // read sources
    input  logic [`BUS_DATA_W-1:0]     reg_rdata_hub,
    input  logic [`BUS_DATA_W-1:0]     reg_rdata_prom,
    input  logic [`BUS_DATA_W-1:0]     reg_rdata_eth,
    input  logic [`BUS_DATA_W-1:0]     reg_rdata_ksz,
    input  logic [`BUS_DATA_W-1:0]     reg_rdata_fw,
    input  logic [`BUS_DATA_W-1:0]     prom_status,
    input  logic [`BUS_DATA_W-1:0]     prom_result,
    input  logic [`BUS_DATA_W-1:0]     eth_result,
    input  logic [`BUS_DATA_W-1:0]     reg_rdata_ext,
    // shared bus out
    output logic [`BUS_ADDR_W-1:0]     reg_raddr,
    output logic [`BUS_ADDR_W-1:0]     reg_waddr,
    output logic [`BUS_DATA_W-1:0]     reg_wdata,
    output logic                       reg_wen,
    output logic                       blk_wen,
    output logic                       blk_wstart,
    output logic                       rt_wen,
    output logic [`RT_ADDR_W-1:0]      rt_waddr,
    output logic [`BUS_DATA_W-1:0]     rt_wdata,
    output logic                       sample_start,
    output logic [`SAMPLE_ADDR_W-1:0]  sample_raddr,
    output logic [`BUS_DATA_W-1:0]     reg_rdata,
    output logic [`BUS_DATA_W-1:0]     ip_address
);

    wr_bus_if                  wr ();            // internal write bus
    board_bus_pkg::reg_addr_u  raddr_sel;        // chosen read address
    logic [`RD_SRC_W-1:0]      rd_src;
    logic                      ip_wr_hit;

    // ------------------------------------------------------------
    // execute / decode / result
    // ------------------------------------------------------------
    host_bus_arbiter u_arb (
        .fw_reg_raddr(fw_reg_raddr),         .fw_reg_waddr(fw_reg_waddr),
        .fw_reg_wdata(fw_reg_wdata),         .fw_reg_wen(fw_reg_wen),
        .fw_blk_wen(fw_blk_wen),             .fw_blk_wstart(fw_blk_wstart),
        .fw_rt_wen(fw_rt_wen),               .fw_rt_waddr(fw_rt_waddr),
        .fw_rt_wdata(fw_rt_wdata),           .fw_sample_start(fw_sample_start),
        .fw_sample_raddr(fw_sample_raddr),   .eth_read_en(eth_read_en),
        .eth_write_en(eth_write_en),         .eth_reg_raddr(eth_reg_raddr),
        .eth_reg_waddr(eth_reg_waddr),       .eth_reg_wdata(eth_reg_wdata),
        .eth_reg_wen(eth_reg_wen),           .eth_blk_wen(eth_blk_wen),
        .eth_blk_wstart(eth_blk_wstart),     .eth_rt_wen(eth_rt_wen),
        .eth_rt_waddr(eth_rt_waddr),         .eth_rt_wdata(eth_rt_wdata),
        .eth_sample_start(eth_sample_start), .eth_sample_read(eth_sample_read),
        .eth_sample_raddr(eth_sample_raddr), .bw_write_en(bw_write_en),
        .bw_reg_waddr(bw_reg_waddr),         .bw_reg_wdata(bw_reg_wdata),
        .bw_reg_wen(bw_reg_wen),             .bw_blk_wen(bw_blk_wen),
        .bw_blk_wstart(bw_blk_wstart),       .sample_busy(sample_busy),
        .sample_chan(sample_chan),           .wr(wr.arb),
        .reg_raddr(raddr_sel),               .rt_wen(rt_wen),
        .rt_waddr(rt_waddr),                 .rt_wdata(rt_wdata),
        .sample_start(sample_start),         .sample_raddr(sample_raddr)
    );

    reg_addr_decoder u_dec (
        .reg_raddr(raddr_sel),
        .wr(wr.snk),
        .rd_src(rd_src),
        .ip_wr_hit(ip_wr_hit)
    );

    rdata_router u_rd (
        .sysclk(sysclk),                     .arst_n(arst_n),
        .rd_src(rd_src),                     .ip_wr_hit(ip_wr_hit),
        .wr(wr.snk),                         .reg_rdata_hub(reg_rdata_hub),
        .reg_rdata_prom(reg_rdata_prom),     .reg_rdata_eth(reg_rdata_eth),
        .reg_rdata_ksz(reg_rdata_ksz),       .reg_rdata_fw(reg_rdata_fw),
        .prom_status(prom_status),           .prom_result(prom_result),
        .eth_result(eth_result),             .reg_rdata_ext(reg_rdata_ext),
        .reg_rdata(reg_rdata),               .ip_address(ip_address)
    );

    // bus out to the board registers
    assign reg_raddr  = raddr_sel;
    assign reg_waddr  = wr.reg_waddr;
    assign reg_wdata  = wr.reg_wdata;
    assign reg_wen    = wr.reg_wen;
    assign blk_wen    = wr.blk_wen;
    assign blk_wstart = wr.blk_wstart;

endmodule

// ==== verif/tb_clkgen.sv ====
// testbench clock generator
module tb_clkgen #(
    parameter real period_ns = 4.0                     // full clock period
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;         // free running, tb ends the run
    end

endmodule

// ==== verif/tb_board_bus.sv ====
// trace-driven testbench for the board register bus, typed compare tasks, bounded waits
`include "board_bus_consts.svh"

module tb_board_bus;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_lines   = 256;                  // trace reader bound
    localparam int reset_limit = 16;                   // cycles allowed for the ip reset value

    // ctrl bit map packed into one trace column
    //   [0] bw_write_en  [1] eth_write_en  [2] eth_read_en  [3] sample_busy
    //   [6:4] reg_wen fw/eth/bw        [7] eth_rt_wen
    //   [10:8] blk_wen fw/eth/bw       [11] fw_rt_wen
    //   [14:12] blk_wstart fw/eth/bw
    //   [16] fw_sample_start  [17] eth_sample_start  [18] eth_sample_read
    logic                      sysclk;
    logic                      arst_n;
    logic [19:0]               ctrl;
    logic [`BUS_ADDR_W-1:0]    fw_addr;                // fw read and write address
    logic [`BUS_ADDR_W-1:0]    eth_addr;               // eth read and write address
    logic [`BW_ADDR_W-1:0]     bw_addr;
    logic [`BUS_DATA_W-1:0]    wdata;                  // each master tags its own top byte
    logic [`CHAN_W-1:0]        chan;
    logic [`BUS_ADDR_W-1:0]    reg_raddr;
    logic [`BUS_ADDR_W-1:0]    reg_waddr;
    logic [`BUS_DATA_W-1:0]    reg_wdata;
    logic                      reg_wen;
    logic                      blk_wen;
    logic                      blk_wstart;
    logic                      rt_wen;
    logic [`RT_ADDR_W-1:0]     rt_waddr;
    logic [`BUS_DATA_W-1:0]    rt_wdata;
    logic                      sample_start;
    logic [`SAMPLE_ADDR_W-1:0] sample_raddr;
    logic [`BUS_DATA_W-1:0]    reg_rdata;
    logic [`BUS_DATA_W-1:0]    ip_address;
    int                        line_no;                // trace line under check

    tb_clkgen #(.period_ns(4.0)) u_clk (.clk(sysclk));

    // fixed per-master words so the winner is visible on every output
    board_bus_top DUT (
        .sysclk(sysclk), .arst_n(arst_n),
        .fw_reg_raddr(fw_addr), .fw_reg_waddr(fw_addr), .fw_reg_wdata({8'hf1, wdata[23:0]}),
        .fw_reg_wen(ctrl[4]), .fw_blk_wen(ctrl[8]), .fw_blk_wstart(ctrl[12]),
        .fw_rt_wen(ctrl[11]), .fw_rt_waddr(4'h3), .fw_rt_wdata(32'hf0f0_0003),
        .fw_sample_start(ctrl[16]), .fw_sample_raddr(6'h15),
        .eth_read_en(ctrl[2]), .eth_write_en(ctrl[1]), .eth_reg_raddr(eth_addr),
        .eth_reg_waddr(eth_addr), .eth_reg_wdata({8'he7, wdata[23:0]}), .eth_reg_wen(ctrl[5]),
        .eth_blk_wen(ctrl[9]), .eth_blk_wstart(ctrl[13]), .eth_rt_wen(ctrl[7]),
        .eth_rt_waddr(4'hc), .eth_rt_wdata(32'he0e0_000c), .eth_sample_start(ctrl[17]),
        .eth_sample_read(ctrl[18]), .eth_sample_raddr(6'h2a),
        .bw_write_en(ctrl[0]), .bw_reg_waddr(bw_addr), .bw_reg_wdata({8'hb3, wdata[23:0]}),
        .bw_reg_wen(ctrl[6]), .bw_blk_wen(ctrl[10]), .bw_blk_wstart(ctrl[14]),
        .sample_busy(ctrl[3]), .sample_chan(chan),
        .reg_rdata_hub(32'h1000_0001), .reg_rdata_prom(32'h2000_0002),
        .reg_rdata_eth(32'h0000_4400), .reg_rdata_ksz(32'h0044_0000),
        .reg_rdata_fw(32'h5000_0005), .prom_status(32'h0000_0008),
        .prom_result(32'h0000_0009), .eth_result(32'h0000_000c),
        .reg_rdata_ext(32'heeee_0000),
        .reg_raddr(reg_raddr), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .blk_wen(blk_wen), .blk_wstart(blk_wstart),
        .rt_wen(rt_wen), .rt_waddr(rt_waddr), .rt_wdata(rt_wdata),
        .sample_start(sample_start), .sample_raddr(sample_raddr),
        .reg_rdata(reg_rdata), .ip_address(ip_address)
    );

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_addr(input string name, input board_bus_pkg::reg_addr_u got,
                              input board_bus_pkg::reg_addr_u exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h (trace line %0d)",
                                name, got, exp, line_no));
        end
    endtask

    task automatic check_data(input string name, input logic [`BUS_DATA_W-1:0] got,
                              input logic [`BUS_DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h (trace line %0d)",
                                name, got, exp, line_no));
        end
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h (trace line %0d)",
                                name, got, exp, line_no));
        end
    endtask

    // ------------------------------------------------------------
    // reset and then one trace line per cycle
    // ------------------------------------------------------------
    initial begin
        int                     fd;
        int                     n;
        int                     waited;
        int                     checked;
        string                  text;
        logic [`BUS_ADDR_W-1:0] exp_waddr;
        logic [`BUS_ADDR_W-1:0] exp_raddr;
        logic [`BUS_DATA_W-1:0] exp_wdata;
        logic [31:0]            exp_flags;             // strobes, rt_waddr, sample_raddr
        logic [`BUS_DATA_W-1:0] exp_rt_wdata;
        logic [`BUS_DATA_W-1:0] exp_rdata;
        logic [`BUS_DATA_W-1:0] exp_ip;

        arst_n    = 1'b0;
        ctrl      = '0;
        fw_addr   = '0;
        eth_addr  = '0;
        bw_addr   = '0;
        wdata     = '0;
        chan      = '0;
        line_no   = 0;
        checked   = 0;
        for (int i = 0; i < 5; i++) begin
            @(posedge sysclk);
        end
        #1 arst_n = 1'b1;

        waited = 0;
        while (ip_address !== `IP_ADDR_RESET) begin
            if (waited >= reset_limit) begin
                abort_run("ip_address never took its reset value");
            end
            @(posedge sysclk);
            waited++;
        end

        fd = $fopen("verif/board_bus_trace.txt", "r");
        if (fd == 0) begin
            abort_run("could not open verif/board_bus_trace.txt");
        end
        while (!$feof(fd)) begin
            if (line_no >= max_lines) begin
                abort_run("trace reader timed out, file longer than the line bound");
            end
            n = $fgets(text, fd);
            line_no++;
            if (n == 0 || text.len() < 2 || text[0] == "#") begin
                continue;                              // comment or blank line
            end
            @(posedge sysclk);
            #1;                                        // drive just after the edge
            n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                        ctrl, fw_addr, eth_addr, bw_addr, wdata, chan,
                        exp_waddr, exp_raddr, exp_wdata, exp_flags, exp_rt_wdata,
                        exp_rdata, exp_ip);
            if (n != 13) begin
                abort_run($sformatf("trace line %0d does not hold 13 fields", line_no));
            end
            #2.5;                                      // sample just before the next edge
            check_addr("reg_waddr", reg_waddr, exp_waddr);
            check_addr("reg_raddr", reg_raddr, exp_raddr);
            check_data("reg_wdata", reg_wdata, exp_wdata);
            check_strobe("reg_wen", reg_wen, exp_flags[0]);
            check_strobe("blk_wen", blk_wen, exp_flags[1]);
            check_strobe("blk_wstart", blk_wstart, exp_flags[2]);
            check_strobe("rt_wen", rt_wen, exp_flags[3]);
            check_strobe("sample_start", sample_start, exp_flags[4]);
            check_data("rt_waddr", rt_waddr, exp_flags[11:8]);
            check_data("sample_raddr", sample_raddr, exp_flags[21:16]);
            check_data("rt_wdata", rt_wdata, exp_rt_wdata);
            check_data("reg_rdata", reg_rdata, exp_rdata);
            check_data("ip_address", ip_address, exp_ip);
            checked++;
        end
        $fclose(fd);
        if (checked == 0) begin
            abort_run("the trace file held no data lines");
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== verif/board_bus_trace.txt ====
# in : ctrl fw_addr eth_addr bw_addr wdata chan, all hex, one bus cycle per line
# out: reg_waddr reg_raddr reg_wdata flags rt_wdata reg_rdata ip_address
# flags: [0] reg_wen [1] blk_wen [2] blk_wstart [3] rt_wen [4] sample_start [11:8] rt_waddr [21:16] sample_raddr
01650 5010 4020 a7 00123456 0 5010 5010 f1123456 00150305 f0f00003 50000005 ffffffff
01651 5010 4020 a7 00123456 0 00a7 5010 b3123456 00150303 f0f00003 50000005 ffffffff
01652 5010 4020 a7 00123456 0 4020 5010 e7123456 00150302 f0f00003 50000005 ffffffff
01653 5010 4020 a7 00123456 0 00a7 5010 b3123456 00150303 f0f00003 50000005 ffffffff
01651 5010 4020 ff 00654321 0 00ff 5010 b3654321 00150303 f0f00003 50000005 ffffffff
00000 5010 4020 ff 00654321 0 5010 5010 f1654321 00150300 f0f00003 50000005 ffffffff
00004 5010 4020 a7 00000001 0 5010 4020 f1000001 00150300 f0f00003 00444400 ffffffff
00008 5010 4020 a7 00000002 3 5010 0030 f1000002 00150300 f0f00003 eeee0000 ffffffff
0000c 5010 4020 a7 00000003 7 5010 0070 f1000003 00150300 f0f00003 eeee0000 ffffffff
00008 5010 4020 a7 00000004 0 5010 0000 f1000004 00150300 f0f00003 eeee0000 ffffffff
00006 5010 4020 a7 00000005 7 4020 4020 e7000005 00150300 f0f00003 00444400 ffffffff
00800 5010 4020 a7 00000006 0 5010 5010 f1000006 00150308 f0f00003 50000005 ffffffff
00080 5010 4020 a7 00000007 0 5010 5010 f1000007 00150c08 e0e0000c 50000005 ffffffff
00880 5010 4020 a7 00000008 0 5010 5010 f1000008 00150c08 e0e0000c 50000005 ffffffff
10000 5010 4020 a7 00000009 0 5010 5010 f1000009 00150310 f0f00003 50000005 ffffffff
20000 5010 4020 a7 0000000a 0 5010 5010 f100000a 00150310 f0f00003 50000005 ffffffff
30008 5010 4020 a7 0000000b 1 5010 0010 f100000b 00150300 f0f00003 eeee0000 ffffffff
40000 5010 4020 a7 0000000c 0 5010 5010 f100000c 002a0300 f0f00003 50000005 ffffffff
50000 5010 4020 a7 0000000d 0 5010 5010 f100000d 002a0310 f0f00003 50000005 ffffffff
00000 1000 4020 a7 00000010 0 1000 1000 f1000010 00150300 f0f00003 10000001 ffffffff
00000 2000 4020 a7 00000011 0 2000 2000 f1000011 00150300 f0f00003 20000002 ffffffff
00000 4000 4020 a7 00000012 0 4000 4000 f1000012 00150300 f0f00003 00444400 ffffffff
00000 5000 4020 a7 00000013 0 5000 5000 f1000013 00150300 f0f00003 50000005 ffffffff
00000 3000 4020 a7 00000014 0 3000 3000 f1000014 00150300 f0f00003 eeee0000 ffffffff
00000 0008 4020 a7 00000015 0 0008 0008 f1000015 00150300 f0f00003 00000008 ffffffff
00000 0009 4020 a7 00000016 0 0009 0009 f1000016 00150300 f0f00003 00000009 ffffffff
00000 000b 4020 a7 00000017 0 000b 000b f1000017 00150300 f0f00003 ffffffff ffffffff
00000 000c 4020 a7 00000018 0 000c 000c f1000018 00150300 f0f00003 0000000c ffffffff
00000 001b 4020 a7 00000019 0 001b 001b f1000019 00150300 f0f00003 eeee0000 ffffffff
00022 000b 000b a7 00a80102 0 000b 000b e7a80102 00150301 f0f00003 ffffffff ffffffff
00000 000b 4020 a7 00000000 0 000b 000b f1000000 00150300 f0f00003 e7a80102 e7a80102
00010 001b 4020 a7 00111111 0 001b 001b f1111111 00150301 f0f00003 eeee0000 e7a80102
00002 000b 000b a7 00222222 0 000b 000b e7222222 00150300 f0f00003 e7a80102 e7a80102
00010 010b 4020 a7 00333333 0 010b 010b f1333333 00150301 f0f00003 e7a80102 e7a80102
00023 000b 000b 0b 00444444 0 000b 000b b3444444 00150300 f0f00003 e7a80102 e7a80102
00041 000b 4020 0b 00c0a801 0 000b 000b b3c0a801 00150301 f0f00003 e7a80102 e7a80102
00010 000b 4020 a7 00000a0a 0 000b 000b f1000a0a 00150301 f0f00003 b3c0a801 b3c0a801
00004 5010 000b a7 00000000 0 5010 000b f1000000 00150300 f0f00003 f1000a0a f1000a0a

// ==== vlog.f ====
+incdir+hw
hw/board_bus_pkg.sv
hw/wr_bus_if.sv
hw/host_bus_arbiter.sv
hw/reg_addr_decoder.sv
hw/rdata_router.sv
hw/board_bus_top.sv
verif/tb_clkgen.sv
verif/tb_board_bus.sv
